//--- uart_pkg.sv
/*
 * Shared definitions for the framed UART string link.
 * The framing character is '&' and must never appear inside a payload.
 * The line format is fixed at 8N1.
 */
`default_nettype none

package uart_pkg;

	typedef logic [7:0] byte_t;	// one data byte on the line or on the host bus.

	localparam byte_t sync_char = 8'h26;	// '&' opens and closes every frame.

	// Receive parser states.
	typedef enum logic [2:0] {
		dec_idle,
		dec_sync1,
		dec_payload,
		dec_end1,
		dec_drop
	} dec_state_e;

	typedef enum logic [2:0] {
		enc_idle,
		enc_head1,
		enc_head2,
		enc_body,
		enc_tail1,
		enc_tail2
	} enc_state_e;

	typedef enum logic [1:0] {
		ser_idle,
		ser_start_bit,
		ser_data_bits,
		ser_stop_bit
	} ser_state_e;	// shared by the serializer and the deserializer.

endpackage

`default_nettype wire

//--- frame_byte_if.sv
/*
 * Decoded payload bytes travelling from the frame parser to the receive store.
 * Every signal is a single-cycle pulse and there is no back-pressure.
 */
`default_nettype none

interface frame_byte_if;

	uart_pkg::byte_t data;	// payload byte, meaningful only with valid.
	logic valid;	// one payload byte this cycle.
	logic eof;	// the frame closed cleanly and may be committed.
	logic abort;	// the frame is broken and must be thrown away.

	modport src (
		output data,
		output valid,
		output eof,
		output abort
	);

	modport dst (
		input data,
		input valid,
		input eof,
		input abort
	);

endinterface

`default_nettype wire

//--- uart_tx.sv
/*
 * 8N1 serializer. One byte takes exactly 10 * CLKS_PER_BIT cycles from start to done.
 * start is only taken while the serializer is idle. The line idles high.
 */
`default_nettype none

module uart_tx #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  uart_pkg::byte_t data,
	input  logic            start,
	output logic            line,
	output logic            done
);

	localparam int CW = $clog2(CLKS_PER_BIT);

	uart_pkg::ser_state_e state;
	logic [CW-1:0] clk_cnt;
	logic [2:0] bit_idx;
	uart_pkg::byte_t shift;
	logic bit_end;

	assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));
	assign done = (state == uart_pkg::ser_stop_bit) && bit_end;	// last cycle of the stop bit.

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= uart_pkg::ser_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			line <= 1'b1;
		end else begin
			clk_cnt <= (state == uart_pkg::ser_idle || bit_end) ? '0 : clk_cnt + 1'b1;
			case (state)
				uart_pkg::ser_idle: begin
					if (start) begin
						state <= uart_pkg::ser_start_bit;
						line <= 1'b0;
					end
				end
				uart_pkg::ser_start_bit: begin
					if (bit_end) begin
						state <= uart_pkg::ser_data_bits;
						bit_idx <= '0;
						line <= shift[0];	// data goes out lsb first.
					end
				end
				uart_pkg::ser_data_bits: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= uart_pkg::ser_stop_bit;
							line <= 1'b1;
						end else begin
							line <= shift[0];
						end
					end
				end
				default: begin
					if (bit_end) begin
						state <= uart_pkg::ser_idle;
					end
				end
			endcase
		end
	end

	// The shift register holds the bits still to be sent.
	always_ff @(posedge sys_clk) begin
		if (state == uart_pkg::ser_idle && start) begin
			shift <= data;
		end else if (bit_end && (state == uart_pkg::ser_start_bit ||
				state == uart_pkg::ser_data_bits)) begin
			shift <= shift >> 1;
		end
	end

endmodule

`default_nettype wire

//--- uart_rx.sv
/*
 * 8N1 deserializer with a two-flop synchronizer and mid-bit sampling.
 * valid pulses about 9.5 bit times after the start edge, plus synchronizer delay.
 * A low stop bit drops the byte silently. data holds until the next byte arrives.
 */
`default_nettype none

module uart_rx #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  logic            line,
	output uart_pkg::byte_t data,
	output logic            valid
);

	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam int HALF = CLKS_PER_BIT / 2;

	uart_pkg::ser_state_e state;
	logic line_meta;
	logic line_sync;
	logic [CW-1:0] clk_cnt;
	logic [2:0] bit_idx;
	uart_pkg::byte_t shift;
	logic bit_end;

	assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));
	assign data = shift;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			line_meta <= 1'b1;
			line_sync <= 1'b1;
			state <= uart_pkg::ser_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			valid <= 1'b0;
		end else begin
			line_meta <= line;
			line_sync <= line_meta;
			valid <= 1'b0;
			case (state)
				uart_pkg::ser_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (!line_sync) begin
						state <= uart_pkg::ser_start_bit;
					end
				end
				uart_pkg::ser_start_bit: begin
					if (clk_cnt == CW'(HALF - 1)) begin
						clk_cnt <= '0;
						// a start bit that is high again at mid-bit was only a glitch.
						state <= line_sync ? uart_pkg::ser_idle : uart_pkg::ser_data_bits;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				uart_pkg::ser_data_bits: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= uart_pkg::ser_stop_bit;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					if (bit_end) begin
						state <= uart_pkg::ser_idle;	// back to idle at mid stop bit.
						valid <= line_sync;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == uart_pkg::ser_data_bits && bit_end) begin
			shift <= {line_sync, shift[7:1]};	// lsb arrives first.
		end
	end

endmodule

`default_nettype wire

//--- frame_decoder.sv
/*
 * Splits received bytes into payload, eof and abort events, one cycle after rx_valid.
 * A payload longer than MAX_LEN is dropped up to its closing sync pair.
 * A broken close or an empty frame returns to idle, so the next "&&" opens a frame.
 */
`default_nettype none

module frame_decoder #(
	parameter int MAX_LEN = 64
) (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  uart_pkg::byte_t rx_byte,
	input  logic            rx_valid,
	frame_byte_if.src       out
);

	localparam int LW = $clog2(MAX_LEN + 1);

	uart_pkg::dec_state_e state;
	logic [LW-1:0] len;
	logic drop_half;	// one sync seen while dropping a long frame.
	logic is_sync;

	assign is_sync = (rx_byte == uart_pkg::sync_char);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= uart_pkg::dec_idle;
			len <= '0;
			drop_half <= 1'b0;
			out.valid <= 1'b0;
			out.eof <= 1'b0;
			out.abort <= 1'b0;
		end else begin
			out.valid <= 1'b0;
			out.eof <= 1'b0;
			out.abort <= 1'b0;
			if (rx_valid) begin
				case (state)
					uart_pkg::dec_idle: begin
						if (is_sync) begin
							state <= uart_pkg::dec_sync1;
						end
					end
					uart_pkg::dec_sync1: begin
						len <= '0;
						state <= is_sync ? uart_pkg::dec_payload : uart_pkg::dec_idle;
					end
					uart_pkg::dec_payload: begin
						if (is_sync) begin
							state <= uart_pkg::dec_end1;
						end else if (len == LW'(MAX_LEN)) begin
							out.abort <= 1'b1;	// too long, throw away what was stored.
							drop_half <= 1'b0;
							state <= uart_pkg::dec_drop;
						end else begin
							out.valid <= 1'b1;
							len <= len + 1'b1;
						end
					end
					uart_pkg::dec_end1: begin
						state <= uart_pkg::dec_idle;
						if (is_sync && len != '0) begin
							out.eof <= 1'b1;
						end else begin
							out.abort <= 1'b1;
						end
					end
					default: begin
						drop_half <= is_sync;
						if (is_sync && drop_half) begin
							state <= uart_pkg::dec_idle;
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx_valid) begin
			out.data <= rx_byte;
		end
	end

endmodule

`default_nettype wire

//--- rx_frame_store.sv
/*
 * Circular receive store. Bytes become visible only after their frame's eof.
 * RX_DEPTH must be a power of two and at least 2.
 * Overflow or abort rolls the frame back and pulses rx_error once per frame.
 */
`default_nettype none

module rx_frame_store #(
	parameter int RX_DEPTH = 256
) (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	frame_byte_if.dst       in,
	input  logic            rx_credit,
	output uart_pkg::byte_t rx_data,
	output logic            rx_valid,
	output logic            rx_last,
	output logic            rx_error
);

	localparam int AW = $clog2(RX_DEPTH);

	uart_pkg::byte_t mem [RX_DEPTH];
	logic last_mem [RX_DEPTH];
	logic [AW:0] wr_spec;
	logic [AW:0] wr_commit;
	logic [AW:0] rd_ptr;
	logic [AW:0] last_idx;
	logic [15:0] credit;	// wide enough for any sensible host grant.
	logic discard;	// the rest of the current frame is thrown away.
	logic full;
	logic emit;

	assign full = ((wr_spec - rd_ptr) == (AW + 1)'(RX_DEPTH));
	assign emit = (rd_ptr != wr_commit) && (credit != '0);
	assign last_idx = wr_spec - 1'b1;

	always_ff @(posedge sys_clk) begin
		if (in.valid && !discard && !full) begin
			mem[wr_spec[AW-1:0]] <= in.data;
			last_mem[wr_spec[AW-1:0]] <= 1'b0;
		end
		if (in.eof && !discard) begin
			last_mem[last_idx[AW-1:0]] <= 1'b1;	// mark the frame's final byte.
		end
		if (emit) begin
			rx_data <= mem[rd_ptr[AW-1:0]];
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_spec <= '0;
			wr_commit <= '0;
			rd_ptr <= '0;
			credit <= '0;
			discard <= 1'b0;
			rx_valid <= 1'b0;
			rx_last <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			rx_valid <= emit;
			rx_last <= emit && last_mem[rd_ptr[AW-1:0]];
			rx_error <= 1'b0;
			credit <= credit + 16'(rx_credit) - 16'(emit);
			if (emit) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (in.abort) begin
				wr_spec <= wr_commit;
				rx_error <= !discard;	// an overflow already reported this frame.
				discard <= 1'b0;
			end else if (in.eof) begin
				if (!discard) begin
					wr_commit <= wr_spec;
				end
				discard <= 1'b0;
			end else if (in.valid && !discard) begin
				if (full) begin
					wr_spec <= wr_commit;
					rx_error <= 1'b1;
					discard <= 1'b1;
				end else begin
					wr_spec <= wr_spec + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- frame_encoder.sv
/*
 * Transmit FIFO and framing FSM. Each string goes out as "&&" payload "&&".
 * The host must respect its credits, since the FIFO does not check for overflow.
 * One tx_credit pulse is returned for every byte that leaves the FIFO.
 */
`default_nettype none

module frame_encoder #(
	parameter int TX_DEPTH = 16
) (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  uart_pkg::byte_t tx_data,
	input  logic            tx_valid,
	input  logic            tx_last,
	output logic            tx_credit,
	output logic            tx_busy,
	output uart_pkg::byte_t ser_data,
	output logic            ser_start,
	input  logic            ser_done
);

	localparam int AW = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
	localparam int CW = $clog2(TX_DEPTH + 1);

	uart_pkg::byte_t fifo_data [TX_DEPTH];
	logic fifo_last [TX_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic fifo_empty;
	logic pop;
	logic ser_busy;	// a character is on the line and done has not come yet.
	uart_pkg::enc_state_e state;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		return (ptr == AW'(TX_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign fifo_empty = (count == '0);
	assign pop = ser_start && (state == uart_pkg::enc_body);
	assign tx_credit = pop;
	assign tx_busy = (state != uart_pkg::enc_idle) || ser_busy || !fifo_empty;
	assign ser_data = (state == uart_pkg::enc_body) ? fifo_data[rd_ptr] : uart_pkg::sync_char;

	always_comb begin
		case (state)
			uart_pkg::enc_head1,
			uart_pkg::enc_head2,
			uart_pkg::enc_tail1,
			uart_pkg::enc_tail2: ser_start = !ser_busy;
			uart_pkg::enc_body: ser_start = !ser_busy && !fifo_empty;
			default: ser_start = 1'b0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (tx_valid) begin
			fifo_data[wr_ptr] <= tx_data;
			fifo_last[wr_ptr] <= tx_last;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			ser_busy <= 1'b0;
			state <= uart_pkg::enc_idle;
		end else begin
			if (tx_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CW'(tx_valid) - CW'(pop);
			if (ser_done) begin
				ser_busy <= 1'b0;
			end else if (ser_start) begin
				ser_busy <= 1'b1;
			end
			case (state)
				uart_pkg::enc_idle: begin
					if (!fifo_empty) begin
						state <= uart_pkg::enc_head1;	// a new string is waiting.
					end
				end
				uart_pkg::enc_head1: begin
					if (ser_start) begin
						state <= uart_pkg::enc_head2;
					end
				end
				uart_pkg::enc_head2: begin
					if (ser_start) begin
						state <= uart_pkg::enc_body;
					end
				end
				uart_pkg::enc_body: begin
					if (pop && fifo_last[rd_ptr]) begin
						state <= uart_pkg::enc_tail1;
					end
				end
				uart_pkg::enc_tail1: begin
					if (ser_start) begin
						state <= uart_pkg::enc_tail2;
					end
				end
				default: begin
					if (ser_start) begin
						state <= uart_pkg::enc_idle;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- uart_string_link.sv
/*
 * Framed string link over an 8N1 UART, byte streams with credits on the host side.
 * The host starts with TX_DEPTH transmit credits; the receive side starts with none.
 * RX_DEPTH must be a power of two and CLKS_PER_BIT at least 4.
 */
`default_nettype none

module uart_string_link #(
	parameter int CLKS_PER_BIT = 868,
	parameter int MAX_LEN = 64,
	parameter int RX_DEPTH = 256,
	parameter int TX_DEPTH = 16
) (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  logic            uart_rx_port,
	output logic            uart_tx_port,
	input  uart_pkg::byte_t tx_data,
	input  logic            tx_valid,
	input  logic            tx_last,
	output logic            tx_credit,
	output logic            tx_busy,
	input  logic            rx_credit,
	output uart_pkg::byte_t rx_data,
	output logic            rx_valid,
	output logic            rx_last,
	output logic            rx_error
);

	uart_pkg::byte_t ser_data;
	logic ser_start;
	logic ser_done;
	uart_pkg::byte_t line_byte;
	logic line_valid;

	frame_byte_if dec_bus ();

	frame_encoder #(
		.TX_DEPTH (TX_DEPTH)
	) u_frame_encoder (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_last   (tx_last),
		.tx_credit (tx_credit),
		.tx_busy   (tx_busy),
		.ser_data  (ser_data),
		.ser_start (ser_start),
		.ser_done  (ser_done)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.data      (ser_data),
		.start     (ser_start),
		.line      (uart_tx_port),
		.done      (ser_done)
	);

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.line      (uart_rx_port),
		.data      (line_byte),
		.valid     (line_valid)
	);

	frame_decoder #(
		.MAX_LEN (MAX_LEN)
	) u_frame_decoder (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (line_byte),
		.rx_valid  (line_valid),
		.out       (dec_bus.src)
	);

	rx_frame_store #(
		.RX_DEPTH (RX_DEPTH)
	) u_rx_frame_store (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.in        (dec_bus.dst),
		.rx_credit (rx_credit),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.rx_last   (rx_last),
		.rx_error  (rx_error)
	);

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
/*
 * Testbench clock and reset source.
 * The clock period is two half periods in ns, reset is low for RESET_CYCLES rising edges.
 */
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD = 4,
	parameter int RESET_CYCLES = 3
) (
	output logic sys_clk,
	output logic sys_rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		sys_clk = 1'b0;
		forever #(HALF_PERIOD) sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		sys_rst_n <= 1'b1;	// release on a clock edge like any other input.
	end

endmodule

`default_nettype wire

//--- tb_uart_string_link.sv
/*
 * Directed testbench for the framed UART string link.
 * Inputs change on rising edges and outputs are sampled on falling edges.
 * Received bytes are recorded in the background, so tests only wait on the count.
 */
`default_nettype none

module tb_uart_string_link;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLKS_PER_BIT = 8;
	localparam int MAX_LEN = 16;
	localparam int RX_DEPTH = 32;
	localparam int TX_DEPTH = 8;
	localparam int WAIT_LIMIT = 5000;	// longest wait in cycles, well beyond one frame.
	localparam int BUF_SIZE = 64;

	logic sys_clk;
	logic sys_rst_n;
	logic uart_rx_port;
	logic uart_tx_port;
	uart_pkg::byte_t tx_data;
	logic tx_valid;
	logic tx_last;
	logic tx_credit;
	logic tx_busy;
	logic rx_credit;
	uart_pkg::byte_t rx_data;
	logic rx_valid;
	logic rx_last;
	logic rx_error;

	logic loopback;	// route the transmit line back into the receiver.
	logic drive_line;
	logic [31:0] rand_state;
	int host_tx_credits;
	int tx_credit_pulses;
	int rx_error_pulses;
	int rx_count;
	uart_pkg::byte_t payload [BUF_SIZE];
	uart_pkg::byte_t rx_buf [BUF_SIZE];
	logic last_buf [BUF_SIZE];
	uart_pkg::byte_t line_buf [BUF_SIZE];

	assign uart_rx_port = loopback ? uart_tx_port : drive_line;

	tb_clock_gen #(
		.HALF_PERIOD  (4),
		.RESET_CYCLES (3)
	) u_clock_gen (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n)
	);

	uart_string_link #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.MAX_LEN      (MAX_LEN),
		.RX_DEPTH     (RX_DEPTH),
		.TX_DEPTH     (TX_DEPTH)
	) UUT (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port),
		.tx_data      (tx_data),
		.tx_valid     (tx_valid),
		.tx_last      (tx_last),
		.tx_credit    (tx_credit),
		.tx_busy      (tx_busy),
		.rx_credit    (rx_credit),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.rx_last      (rx_last),
		.rx_error     (rx_error)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected === actual) else
			report_failure($sformatf("Mismatch in %s: expected %0h, actual %0h",
				test, expected, actual));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Payload bytes span the whole byte range, with the sync character folded away.
	task automatic fill_random(input int len);
		uart_pkg::byte_t value;
		for (int i = 0; i < len; i++) begin
			rand_state = xorshift32(rand_state);
			value = rand_state[7:0];
			payload[i] = (value == uart_pkg::sync_char) ? ~value : value;
		end
	endtask

	// Host side of the transmit credits, refilled by tx_credit pulses.
	always @(negedge sys_clk) begin
		if (tx_credit) begin
			host_tx_credits = host_tx_credits + 1;
			tx_credit_pulses = tx_credit_pulses + 1;
		end
		if (rx_error) begin
			rx_error_pulses = rx_error_pulses + 1;
		end
		if (rx_valid) begin
			assert (rx_count < BUF_SIZE) else
				report_failure("more bytes were received than the capture buffer holds");
			rx_buf[rx_count] = rx_data;
			last_buf[rx_count] = rx_last;
			rx_count = rx_count + 1;
		end
	end

	task automatic push_string(input int len);
		int guard;
		for (int i = 0; i < len; i++) begin
			guard = 0;
			@(posedge sys_clk);
			tx_valid <= 1'b0;
			while (host_tx_credits == 0) begin
				guard++;
				assert (guard < WAIT_LIMIT) else
					report_failure("no transmit credit came back in time");
				@(posedge sys_clk);
			end
			tx_data <= payload[i];
			tx_valid <= 1'b1;
			tx_last <= (i == len - 1);
			host_tx_credits = host_tx_credits - 1;
		end
		@(posedge sys_clk);
		tx_valid <= 1'b0;
		tx_last <= 1'b0;
	endtask

	task automatic grant_credits(input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge sys_clk);
			rx_credit <= 1'b1;
		end
		@(posedge sys_clk);
		rx_credit <= 1'b0;
	endtask

	task automatic drive_serial_byte(input uart_pkg::byte_t value);
		@(posedge sys_clk);
		drive_line <= 1'b0;	// start bit.
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(posedge sys_clk);
			drive_line <= value[i];
		end
		repeat (CLKS_PER_BIT) @(posedge sys_clk);
		drive_line <= 1'b1;
		repeat (CLKS_PER_BIT + 2) @(posedge sys_clk);	// stop bit and a short idle gap.
	endtask

	task automatic send_serial_text(input string text);
		for (int i = 0; i < text.len(); i++) begin
			drive_serial_byte(text[i]);
		end
	endtask

	// Decodes one 8N1 character from the transmit line at mid-bit.
	task automatic capture_line_byte(output uart_pkg::byte_t value);
		int guard;
		guard = 0;
		@(negedge sys_clk);
		while (uart_tx_port !== 1'b0) begin
			guard++;
			assert (guard < WAIT_LIMIT) else
				report_failure("no start bit appeared on the transmit line");
			@(negedge sys_clk);
		end
		repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
		assert (uart_tx_port === 1'b0) else
			report_failure("the start bit on the transmit line was too short");
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
			value[i] = uart_tx_port;
		end
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		assert (uart_tx_port === 1'b1) else
			report_failure("the stop bit on the transmit line was low");
	endtask

	task automatic collect_frame(input int total);
		int guard;
		guard = 0;
		while (rx_count < total) begin
			guard++;
			assert (guard < WAIT_LIMIT) else
				report_failure("received bytes did not arrive in time");
			@(negedge sys_clk);
		end
	endtask

	task automatic wait_tx_idle();
		int guard;
		guard = 0;
		@(negedge sys_clk);
		while (tx_busy) begin
			guard++;
			assert (guard < WAIT_LIMIT) else
				report_failure("the transmitter stayed busy too long");
			@(negedge sys_clk);
		end
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) @(negedge sys_clk);
	endtask

	task automatic check_frame(input string test, input int len);
		check_value(test, len, rx_count);
		for (int i = 0; i < len; i++) begin
			check_value(test, payload[i], rx_buf[i]);
			check_value(test, (i == len - 1), last_buf[i]);	// rx_last on the final byte only.
		end
	endtask

	task automatic test_reset_state();
		@(negedge sys_clk);
		check_value("reset_state", 1, uart_tx_port);
		check_value("reset_state", 0, tx_busy);
		check_value("reset_state", 0, tx_credit);
		check_value("reset_state", 0, rx_valid);
		check_value("reset_state", 0, rx_last);
		check_value("reset_state", 0, rx_error);
	endtask

	task automatic test_tx_framing();
		logic busy_at_end;
		loopback = 1'b0;
		tx_credit_pulses = 0;
		fill_random(5);
		fork
			push_string(5);
			begin
				for (int k = 0; k < 9; k++) begin
					capture_line_byte(line_buf[k]);
				end
				busy_at_end = tx_busy;
			end
		join
		for (int k = 0; k < 9; k++) begin
			if (k < 2 || k > 6) begin
				check_value("tx_framing", uart_pkg::sync_char, line_buf[k]);
			end else begin
				check_value("tx_framing", payload[k - 2], line_buf[k]);
			end
		end
		check_value("tx_framing", 1, busy_at_end);	// still busy during the last stop bit.
		wait_tx_idle();
		check_value("tx_framing", 5, tx_credit_pulses);
		check_value("tx_framing", TX_DEPTH, host_tx_credits);
	endtask

	task automatic test_loopback();
		loopback = 1'b1;
		grant_credits(1 + MAX_LEN);	// exactly what both frames use, so none are left over.
		rx_count = 0;
		fill_random(1);
		push_string(1);
		collect_frame(1);
		idle_cycles(20);
		check_frame("loopback", 1);
		rx_count = 0;
		fill_random(MAX_LEN);
		push_string(MAX_LEN);
		collect_frame(MAX_LEN);
		idle_cycles(20);
		check_frame("loopback", MAX_LEN);
		wait_tx_idle();
	endtask

	task automatic test_credit_gating();
		loopback = 1'b1;
		rx_count = 0;
		fill_random(6);
		push_string(6);
		wait_tx_idle();
		idle_cycles(40);
		check_value("credit_gating", 0, rx_count);
		grant_credits(4);
		collect_frame(4);
		idle_cycles(40);
		check_value("credit_gating", 4, rx_count);
		grant_credits(2);
		collect_frame(6);
		idle_cycles(20);
		check_frame("credit_gating", 6);
	endtask

	task automatic test_malformed();
		int err_base;
		loopback = 1'b0;
		rx_count = 0;
		err_base = rx_error_pulses;
		grant_credits(2);
		send_serial_text("&&ab&x");
		send_serial_text("&&cd&&");
		collect_frame(2);
		idle_cycles(20);
		check_value("malformed", err_base + 1, rx_error_pulses);
		payload[0] = "c";
		payload[1] = "d";
		check_frame("malformed", 2);
	endtask

	task automatic test_limits();
		int err_base;
		rx_count = 0;
		err_base = rx_error_pulses;
		grant_credits(3);
		loopback = 1'b1;
		fill_random(MAX_LEN + 1);
		push_string(MAX_LEN + 1);
		wait_tx_idle();
		idle_cycles(20);
		check_value("limits", err_base + 1, rx_error_pulses);
		check_value("limits", 0, rx_count);
		loopback = 1'b0;
		send_serial_text("&&&&");	// an empty frame is an error as well.
		idle_cycles(20);
		check_value("limits", err_base + 2, rx_error_pulses);
		check_value("limits", 0, rx_count);
		loopback = 1'b1;
		fill_random(3);
		push_string(3);
		collect_frame(3);
		wait_tx_idle();
		idle_cycles(20);
		check_frame("limits", 3);
		check_value("limits", err_base + 2, rx_error_pulses);
	endtask

	initial begin
		#(2_000_000);
		report_failure("the simulation ran past its time limit");
	end

	initial begin
		int guard;
		tx_data = '0;
		tx_valid = 1'b0;
		tx_last = 1'b0;
		rx_credit = 1'b0;
		drive_line = 1'b1;
		loopback = 1'b0;
		rand_state = 32'h6364;
		host_tx_credits = TX_DEPTH;
		tx_credit_pulses = 0;
		rx_error_pulses = 0;
		rx_count = 0;
		guard = 0;
		@(posedge sys_clk);
		while (!sys_rst_n) begin
			guard++;
			assert (guard < 100) else report_failure("reset was never released");
			@(posedge sys_clk);
		end
		test_reset_state();
		test_tx_framing();
		test_loopback();
		test_credit_gating();
		test_malformed();
		test_limits();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
uart_pkg.sv
frame_byte_if.sv
uart_tx.sv
uart_rx.sv
frame_decoder.sv
rx_frame_store.sv
frame_encoder.sv
uart_string_link.sv
tb_clock_gen.sv
tb_uart_string_link.sv
